// File: rtl/core_pkg.sv
`default_nettype none

package core_pkg;

    // Datapath widths
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 for ALU and branch words
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    // Register-register view
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } instr_r_s;

    // Immediate and branch view, I-type and B-type share the split
    typedef struct packed {
        logic [11:0]           imm_hi;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } instr_ib_s;

    typedef union packed {
        instr_r_s  r;
        instr_ib_s ib;
    } instr_u;

    // Instruction memory request and response
    typedef struct packed {
        logic            req;
        logic [XLEN-1:0] addr;
    } imem_req_s;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] instr;
    } imem_rsp_s;

    // One queued instruction with its address
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_entry_s;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_s;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } retire_s;

endpackage

`default_nettype wire

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_pkg::imem_rsp_s    imem_rsp_i,
    input  logic                   full_i,
    input  logic                   pop_i,
    input  core_pkg::redirect_s    redirect_i,
    output core_pkg::imem_req_s    imem_req_o,
    output logic                   push_o,
    output core_pkg::fetch_entry_s push_data_o
);
    import core_pkg::*;

    logic            req_q;
    logic            stale_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] addr_q;

    logic            ack;
    logic            issue;
    logic [XLEN-1:0] fetch_pc;

    // Only responses to an outstanding request count
    assign ack = req_q & imem_rsp_i.ack;

    // One request in flight, and only when the queue has room for its word
    assign issue = ~req_q & (~full_i | pop_i);

    // A taken branch overrides the sequential address in the same cycle
    assign fetch_pc = redirect_i.valid ? redirect_i.target : pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q   <= 1'b0;
            stale_q <= 1'b0;
            pc_q    <= RESET_PC;
        end else begin
            if (issue) begin
                req_q <= 1'b1;
                pc_q  <= fetch_pc + XLEN'(4);
            end else begin
                if (ack) begin
                    req_q <= 1'b0;
                end
                pc_q <= fetch_pc;
            end

            // Response still due for a pre-redirect address
            if (ack) begin
                stale_q <= 1'b0;
            end else if (req_q && redirect_i.valid) begin
                stale_q <= 1'b1;
            end
        end
    end

    // Address held steady while the request waits for ack
    always_ff @(posedge clk) begin
        if (issue) begin
            addr_q <= fetch_pc;
        end
    end

    assign imem_req_o.req  = req_q;
    assign imem_req_o.addr = addr_q;

    // Stale words are dropped here, the queue handles a same-cycle flush
    assign push_o            = ack & ~stale_q;
    assign push_data_o.pc    = addr_q;
    assign push_data_o.instr = imem_rsp_i.instr;

endmodule

`default_nettype wire

// File: rtl/instr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module instr_queue (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push_i,
    input  core_pkg::fetch_entry_s push_data_i,
    input  logic                   pop_i,
    input  logic                   flush_i,
    output logic                   full_o,
    output logic                   valid_o,
    output core_pkg::fetch_entry_s head_o
);
    import core_pkg::*;

    fetch_entry_s entries [2];
    logic         wr_ptr_q;
    logic         rd_ptr_q;
    logic [1:0]   count_q;

    logic         do_push;
    logic         do_pop;

    assign full_o  = (count_q == 2'd2);
    assign valid_o = (count_q != 2'd0);
    assign head_o  = entries[rd_ptr_q];

    assign do_pop  = pop_i & valid_o;
    // Push into a full queue only works alongside a pop
    assign do_push = push_i & ~flush_i & (~full_o | do_pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else if (flush_i) begin
            // Drop everything, including this cycle's push
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (do_pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid_i,
    input  core_pkg::fetch_entry_s head_i,
    input  logic                   retire_ready_i,
    output logic                   pop_o,
    output core_pkg::redirect_s    redirect_o,
    output logic                   retire_valid_o,
    output core_pkg::retire_s      retire_o
);
    import core_pkg::*;

    logic [XLEN-1:0]       regs [2**REG_ADDR_W];

    instr_u                instr;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;

    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       i_imm;
    logic [XLEN-1:0]       b_imm;

    logic                  is_op;
    logic                  is_addi;
    logic                  is_alu;
    logic                  is_branch;
    logic                  taken;

    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       alu_result;

    logic                  can_accept;
    logic                  fire;
    logic                  wr_en;

    logic                  ret_valid_q;
    retire_s               ret_q;

    // Same word, two field layouts
    assign instr  = head_i.instr;
    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;
    assign rs1    = instr.r.rs1;
    assign rs2    = instr.r.rs2;
    assign rd     = instr.r.rd;

    assign i_imm = {{20{instr.ib.imm_hi[11]}}, instr.ib.imm_hi};

    // B-type offset scattered over both immediate fields
    assign b_imm = {{19{instr.ib.imm_hi[11]}},
                    instr.ib.imm_hi[11],
                    instr.ib.imm_lo[0],
                    instr.ib.imm_hi[10:5],
                    instr.ib.imm_lo[4:1],
                    1'b0};

    // x0 always reads zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_comb begin
        is_op = 1'b0;
        if (opcode == OPC_OP) begin
            case (funct3)
                F3_ADD_SUB: is_op = (funct7 == 7'd0) || (funct7 == F7_SUB);
                F3_XOR,
                F3_OR,
                F3_AND:     is_op = (funct7 == 7'd0);
                default:    is_op = 1'b0;
            endcase
        end
    end

    assign is_addi   = (opcode == OPC_OP_IMM) && (funct3 == F3_ADD_SUB);
    assign is_alu    = is_op | is_addi;
    assign is_branch = (opcode == OPC_BRANCH) &&
                       ((funct3 == F3_BEQ) || (funct3 == F3_BNE));

    // ALU
    assign op_b = is_op ? rs2_data : i_imm;

    always_comb begin
        case (funct3)
            F3_XOR:  alu_result = rs1_data ^ op_b;
            F3_OR:   alu_result = rs1_data | op_b;
            F3_AND:  alu_result = rs1_data & op_b;
            default: begin
                if (is_op && (funct7 == F7_SUB)) begin
                    alu_result = rs1_data - op_b;
                end else begin
                    alu_result = rs1_data + op_b;
                end
            end
        endcase
    end

    // BNE inverts the equality test
    assign taken = is_branch & ((rs1_data == rs2_data) ^ (funct3 == F3_BNE));

    // Everything waits while a result is held, branches too
    assign can_accept = ~ret_valid_q | retire_ready_i;
    assign pop_o      = valid_i & can_accept;
    assign fire       = pop_o;
    assign wr_en      = fire & is_alu & (rd != '0);

    assign redirect_o.valid  = fire & taken;
    assign redirect_o.target = head_i.pc + b_imm;

    // Register file, written as the retire register loads
    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[rd] <= alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ret_valid_q <= 1'b0;
        end else if (wr_en) begin
            ret_valid_q <= 1'b1;
        end else if (retire_ready_i) begin
            ret_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ret_q.pc   <= head_i.pc;
            ret_q.rd   <= rd;
            ret_q.data <= alu_result;
        end
    end

    assign retire_valid_o = ret_valid_q;
    assign retire_o       = ret_q;

endmodule

`default_nettype wire

// File: rtl/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::imem_rsp_s imem_rsp_i,
    input  logic                retire_ready_i,
    output core_pkg::imem_req_s imem_req_o,
    output logic                retire_valid_o,
    output core_pkg::retire_s   retire_o
);
    import core_pkg::*;

    // Fetch to queue
    logic         push;
    fetch_entry_s push_data;
    logic         full;

    // Queue to execute
    logic         head_valid;
    fetch_entry_s head;
    logic         pop;

    // Taken branch back to fetch and queue
    redirect_s    redirect;

    fetch_unit u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_rsp_i  (imem_rsp_i),
        .full_i      (full),
        .pop_i       (pop),
        .redirect_i  (redirect),
        .imem_req_o  (imem_req_o),
        .push_o      (push),
        .push_data_o (push_data)
    );

    instr_queue u_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .flush_i     (redirect.valid),
        .full_o      (full),
        .valid_o     (head_valid),
        .head_o      (head)
    );

    exec_unit u_exec (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_i        (head_valid),
        .head_i         (head),
        .retire_ready_i (retire_ready_i),
        .pop_o          (pop),
        .redirect_o     (redirect),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

`default_nettype wire

// File: tb/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import core_pkg::*;

    localparam int          CLK_PERIOD     = 100;
    localparam int          PROG_LEN       = 200;
    localparam int          NUM_INIT       = 8;
    localparam int          TIMEOUT_CYCLES = PROG_LEN * 12;
    localparam int          DRAIN_CYCLES   = 40;
    localparam logic [31:0] SEED           = 32'h77af;

    // Operation kinds of the generated program, branches last
    localparam int K_ADDI = 0;
    localparam int K_ADD  = 1;
    localparam int K_SUB  = 2;
    localparam int K_AND  = 3;
    localparam int K_OR   = 4;
    localparam int K_XOR  = 5;
    localparam int K_BEQ  = 6;
    localparam int K_BNE  = 7;

    logic       clk            = 1'b0;
    logic       rst_n          = 1'b0;
    imem_rsp_s  imem_rsp_i     = '0;
    logic       retire_ready_i = 1'b0;
    imem_req_s  imem_req_o;
    logic       retire_valid_o;
    retire_s    retire_o;

    // Program in both forms, fields for the model and words for memory
    logic [XLEN-1:0]       prog_word [PROG_LEN];
    int                    prog_kind [PROG_LEN];
    logic [REG_ADDR_W-1:0] prog_rd   [PROG_LEN];
    logic [REG_ADDR_W-1:0] prog_rs1  [PROG_LEN];
    logic [REG_ADDR_W-1:0] prog_rs2  [PROG_LEN];
    logic [12:0]           prog_imm  [PROG_LEN];

    logic [XLEN-1:0]       exp_pc    [PROG_LEN];
    logic [REG_ADDR_W-1:0] exp_rd    [PROG_LEN];
    logic [XLEN-1:0]       exp_data  [PROG_LEN];
    int                    exp_cnt        = 0;
    int                    match_cnt      = 0;
    int                    cycle_cnt      = 0;

    logic [31:0]           stim_rng       = SEED;
    int                    ack_wait       = 0;
    logic                  ack_seen       = 1'b0;
    logic                  held           = 1'b0;
    logic                  first_req_seen = 1'b0;
    retire_s               held_ret;

    core_top u_core_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_rsp_i     (imem_rsp_i),
        .retire_ready_i (retire_ready_i),
        .imem_req_o     (imem_req_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [XLEN-1:0] itype_word(logic [11:0] imm, logic [4:0] rs1,
                                                   logic [2:0] f3, logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [XLEN-1:0] rtype_word(logic [6:0] f7, logic [4:0] rs2,
                                                   logic [4:0] rs1, logic [2:0] f3,
                                                   logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    // B-type offset bits scattered as the ISA defines them
    function automatic logic [XLEN-1:0] branch_word(logic [12:0] off, logic [4:0] rs2,
                                                    logic [4:0] rs1, logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [XLEN-1:0] mem_word(logic [XLEN-1:0] addr);
        logic [XLEN-1:0] idx;
        logic [XLEN-1:0] word;
        idx = (addr - RESET_PC) >> 2;
        if (idx < XLEN'(PROG_LEN)) begin
            word = prog_word[idx[7:0]];
        end else begin
            word = NOP_INSTR;
        end
        return word;
    endfunction

    task automatic make_program();
        logic [31:0]           rng;
        logic [REG_ADDR_W-1:0] last_rd;
        int                    i;
        rng     = SEED;
        last_rd = '0;
        for (i = 0; i < PROG_LEN; i++) begin
            rng = xorshift32(rng);
            if (i < NUM_INIT) begin
                // Initial values for x0 to x7
                prog_kind[i] = K_ADDI;
                prog_rd[i]   = REG_ADDR_W'(i);
                prog_rs1[i]  = '0;
                prog_rs2[i]  = '0;
                prog_imm[i]  = {rng[11], rng[11:0]};
            end else begin
                prog_kind[i] = int'(rng[2:0]);
                prog_rd[i]   = {2'b00, rng[5:3]};
                prog_rs1[i]  = last_rd;
                prog_rs2[i]  = {2'b00, rng[8:6]};
                prog_imm[i]  = {rng[20], rng[20:9]};
                if (prog_kind[i] >= K_BEQ) begin
                    prog_rs1[i] = {2'b00, rng[11:9]};
                    // Equal operands now and then so BEQ gets taken
                    if (rng[13:12] == 2'b00) begin
                        prog_rs2[i] = prog_rs1[i];
                    end
                    prog_imm[i] = rng[14] ? 13'd12 : 13'd8;
                end
            end
            if (prog_kind[i] < K_BEQ) begin
                last_rd = prog_rd[i];
            end
            case (prog_kind[i])
                K_ADDI: prog_word[i] = itype_word(prog_imm[i][11:0], prog_rs1[i],
                                                  F3_ADD_SUB, prog_rd[i]);
                K_ADD:  prog_word[i] = rtype_word(7'd0, prog_rs2[i], prog_rs1[i],
                                                  F3_ADD_SUB, prog_rd[i]);
                K_SUB:  prog_word[i] = rtype_word(F7_SUB, prog_rs2[i], prog_rs1[i],
                                                  F3_ADD_SUB, prog_rd[i]);
                K_AND:  prog_word[i] = rtype_word(7'd0, prog_rs2[i], prog_rs1[i],
                                                  F3_AND, prog_rd[i]);
                K_OR:   prog_word[i] = rtype_word(7'd0, prog_rs2[i], prog_rs1[i],
                                                  F3_OR, prog_rd[i]);
                K_XOR:  prog_word[i] = rtype_word(7'd0, prog_rs2[i], prog_rs1[i],
                                                  F3_XOR, prog_rd[i]);
                K_BEQ:  prog_word[i] = branch_word(prog_imm[i], prog_rs2[i], prog_rs1[i],
                                                   F3_BEQ);
                default: prog_word[i] = branch_word(prog_imm[i], prog_rs2[i], prog_rs1[i],
                                                    F3_BNE);
            endcase
        end
    endtask

    // Instruction-level model of the program, fills the expected retire list
    function automatic int build_expected();
        logic [XLEN-1:0] regs [2**REG_ADDR_W];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] result;
        logic            taken;
        int              idx;
        int              n;
        for (idx = 0; idx < 2**REG_ADDR_W; idx++) begin
            regs[idx] = '0;
        end
        idx = 0;
        n   = 0;
        while (idx < PROG_LEN) begin
            a      = regs[prog_rs1[idx]];
            b      = regs[prog_rs2[idx]];
            imm    = {{(XLEN-12){prog_imm[idx][11]}}, prog_imm[idx][11:0]};
            result = '0;
            taken  = 1'b0;
            case (prog_kind[idx])
                K_ADDI:  result = a + imm;
                K_ADD:   result = a + b;
                K_SUB:   result = a - b;
                K_AND:   result = a & b;
                K_OR:    result = a | b;
                K_XOR:   result = a ^ b;
                K_BEQ:   taken  = (a == b);
                default: taken  = (a != b);
            endcase
            if (prog_kind[idx] < K_BEQ) begin
                // x0 stays zero and never shows on the retire port
                if (prog_rd[idx] != '0) begin
                    regs[prog_rd[idx]] = result;
                    exp_pc[n]          = RESET_PC + (XLEN'(idx) << 2);
                    exp_rd[n]          = prog_rd[idx];
                    exp_data[n]        = result;
                    n++;
                end
                idx++;
            end else if (taken) begin
                idx = idx + int'(prog_imm[idx] >> 2);
            end else begin
                idx++;
            end
        end
        return n;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected));
        end
    endtask

    // Memory model and retire back-pressure
    always @(negedge clk) begin
        if (!rst_n) begin
            imem_rsp_i     <= '0;
            retire_ready_i <= 1'b0;
        end else begin
            stim_rng = xorshift32(stim_rng);
            retire_ready_i <= (stim_rng[1:0] != 2'b00);
            if (!imem_req_o.req) begin
                imem_rsp_i <= '0;
                ack_wait   = int'(stim_rng[3:2]);
            end else if (ack_wait == 0) begin
                imem_rsp_i.ack   <= 1'b1;
                imem_rsp_i.instr <= mem_word(imem_req_o.addr);
                ack_seen         <= 1'b1;
            end else begin
                imem_rsp_i <= '0;
                ack_wait   = ack_wait - 1;
            end
        end
    end

    // Retire checker, sampled on the edge where the handshake happens
    always @(posedge clk) begin
        if (rst_n) begin
            if (held) begin
                check_value("retire_valid_o", XLEN'(retire_valid_o), XLEN'(1'b1));
                check_value("retire_o.pc", retire_o.pc, held_ret.pc);
                check_value("retire_o.rd", XLEN'(retire_o.rd), XLEN'(held_ret.rd));
                check_value("retire_o.data", retire_o.data, held_ret.data);
            end
            if (imem_req_o.req && !first_req_seen) begin
                check_value("imem_req_o.addr", imem_req_o.addr, RESET_PC);
                first_req_seen = 1'b1;
            end
            if (retire_valid_o && !ack_seen) begin
                abort_run("A result was retired before any instruction was acknowledged");
            end
            if (retire_valid_o && retire_ready_i) begin
                if (match_cnt >= exp_cnt) begin
                    abort_run("A result was retired after the expected list was complete");
                end else begin
                    check_value("retire_o.pc", retire_o.pc, exp_pc[match_cnt]);
                    check_value("retire_o.rd", XLEN'(retire_o.rd), XLEN'(exp_rd[match_cnt]));
                    check_value("retire_o.data", retire_o.data, exp_data[match_cnt]);
                    match_cnt = match_cnt + 1;
                end
            end
            held     = retire_valid_o && !retire_ready_i;
            held_ret = retire_o;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles with %0d of %0d results retired",
                                cycle_cnt, match_cnt, exp_cnt));
        end
    end

    initial begin
        make_program();
        exp_cnt = build_expected();
        repeat (2) @(negedge clk);
        // Reset state before release
        check_value("imem_req_o.req", XLEN'(imem_req_o.req), XLEN'(1'b0));
        check_value("retire_valid_o", XLEN'(retire_valid_o), XLEN'(1'b0));
        rst_n <= 1'b1;
        while (match_cnt < exp_cnt) begin
            @(negedge clk);
        end
        // Quiet period so a spurious extra retire is still caught
        repeat (DRAIN_CYCLES) @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/instr_queue.sv
rtl/exec_unit.sv
rtl/core_top.sv
tb/tb_core.sv

// File: Makefile
TOP := tb_core

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -j 0 --top-module $(TOP) -f tb.f -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir
